//--- logic/adder_tree_cfg.svh
`ifndef ADDER_TREE_CFG_SVH
`define ADDER_TREE_CFG_SVH

//////////////////////////////////////////////////
// adder tree sizing
//////////////////////////////////////////////////

// number of operands summed per clock
`define ADDER_TREE_OPS_N 16

// bits per operand, unsigned
`define ADDER_TREE_OP_W 3

// op width plus log2 of op count, holds 16 * 7 = 112
`define ADDER_TREE_SUM_W 7

// input to output, 4 tree layers then 2 merge stages
`define ADDER_TREE_LATENCY 6

`endif

//--- logic/adder_tree_pkg.sv
`include "adder_tree_cfg.svh"

package adder_tree_pkg;

    //////////////////////////////////////////////////
    // datapath types
    //////////////////////////////////////////////////

    typedef logic [`ADDER_TREE_OP_W-1:0] operand_t;

    // all intermediate words run at full output width
    typedef logic [`ADDER_TREE_SUM_W-1:0] wide_t;

    // one full operand set, lane 0 in the low bits
    typedef operand_t [`ADDER_TREE_OPS_N-1:0] operand_set_t;

    typedef struct packed {
        wide_t sum;
        wide_t carry;
    } csa_pair_t;

    //////////////////////////////////////////////////
    // layer planning
    //////////////////////////////////////////////////

    // 3:2 layers needed to get ops_n words down to two
    function automatic int csa_layer_count(input int ops_n);
        int n;
        int layers;
        n = ops_n;
        layers = 0;
        while (n > 2) begin
            // full groups of three give two, leftovers ride along
            n = (n / 3) * 2 + n % 3;
            layers++;
        end
        return layers;
    endfunction

    // words entering layer number 'layer'
    function automatic int csa_layer_width(input int ops_n, input int layer);
        int n;
        n = ops_n;
        for (int l = 0; l < layer; l++) begin
            n = (n / 3) * 2 + n % 3;
        end
        return n;
    endfunction

    // single 3:2 compressor, carry already weighted by two
    function automatic csa_pair_t csa_compress(input wide_t a, input wide_t b, input wide_t c);
        csa_pair_t res;
        res.sum = a ^ b ^ c;
        res.carry = ((a & b) | (a & c) | (b & c)) << 1;
        return res;
    endfunction

endpackage

//--- logic/csa_reduction_tree.sv
`timescale 1ns/100ps
`include "adder_tree_cfg.svh"

module csa_reduction_tree
    import adder_tree_pkg::*;
#(
    parameter int P_OPS_N = `ADDER_TREE_OPS_N / 2
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  operand_t [P_OPS_N-1:0] i_ops,
    output csa_pair_t              o_pair
);

    // 8 ops: 8 -> 6 -> 4 -> 3 -> 2
    localparam int LAYERS_N = csa_layer_count(P_OPS_N);

    //////////////////////////////////////////////////
    // registered 3:2 layers
    //////////////////////////////////////////////////

    for (genvar l = 0; l < LAYERS_N; l++) begin : g_layer

        localparam int IN_N = csa_layer_width(P_OPS_N, l);
        localparam int GROUPS_N = IN_N / 3;
        localparam int LEFT_N = IN_N % 3;
        localparam int OUT_N = csa_layer_width(P_OPS_N, l + 1);

        wide_t [IN_N-1:0]  layer_in;
        wide_t [OUT_N-1:0] layer_d;
        wide_t [OUT_N-1:0] layer_q;

        // layer input select
        if (l == 0) begin : g_from_ops
            always_comb begin
                for (int i = 0; i < IN_N; i++) begin
                    // zero extend to working width
                    layer_in[i] = wide_t'(i_ops[i]);
                end
            end
        end else begin : g_from_prev
            // previous layer output width equals this layer input width
            assign layer_in = g_layer[l-1].layer_q;
        end

        // group i lands on lanes 2i (sum) and 2i+1 (carry)
        always_comb begin
            csa_pair_t grp;
            for (int g = 0; g < GROUPS_N; g++) begin
                grp = csa_compress(layer_in[3*g], layer_in[3*g+1], layer_in[3*g+2]);
                layer_d[2*g] = grp.sum;
                layer_d[2*g+1] = grp.carry;
            end
            // leftovers stay unchanged, just get a register for alignment
            for (int r = 0; r < LEFT_N; r++) begin
                layer_d[2*GROUPS_N+r] = layer_in[3*GROUPS_N+r];
            end
        end

        always_ff @(posedge clk or negedge i_rst_n) begin
            if (!i_rst_n) begin
                layer_q <= '0;
            end else begin
                layer_q <= layer_d;
            end
        end

    end

    //////////////////////////////////////////////////
    // output pair
    //////////////////////////////////////////////////

    // last layer always reduces three words, so lanes 0/1 are sum/carry
    assign o_pair.sum = g_layer[LAYERS_N-1].layer_q[0];
    assign o_pair.carry = g_layer[LAYERS_N-1].layer_q[1];

    // x on any lane would corrupt every later total
    a_pair_known : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !$isunknown(o_pair)
    );

endmodule

//--- logic/tree_merge.sv
`timescale 1ns/100ps
`include "adder_tree_cfg.svh"

module tree_merge
    import adder_tree_pkg::*;
(
    input  logic      clk,
    input  logic      i_rst_n,
    input  csa_pair_t i_lo,
    input  csa_pair_t i_hi,
    output wide_t     o_sum
);

    csa_pair_t step_a;
    csa_pair_t step_b;
    csa_pair_t pair_q;

    // one spare bit to see a carry out of the final add
    logic [`ADDER_TREE_SUM_W:0] add_full;

    //////////////////////////////////////////////////
    // 4:2 compression
    //////////////////////////////////////////////////

    // four words to three, then three to two
    always_comb begin
        step_a = csa_compress(i_lo.sum, i_lo.carry, i_hi.sum);
        step_b = csa_compress(step_a.sum, step_a.carry, i_hi.carry);
    end

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pair_q <= '0;
        end else begin
            pair_q <= step_b;
        end
    end

    //////////////////////////////////////////////////
    // carry-propagate add
    //////////////////////////////////////////////////

    assign add_full = {1'b0, pair_q.sum} + {1'b0, pair_q.carry};

    always_ff @(posedge clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_sum <= '0;
        end else begin
            o_sum <= add_full[`ADDER_TREE_SUM_W-1:0];
        end
    end

    // pair words never add past the true total, which fits in SUM_W bits
    a_no_carry_out : assert property (
        @(posedge clk) disable iff (!i_rst_n)
        !add_full[`ADDER_TREE_SUM_W]
    );

endmodule

//--- logic/adder_tree_top.sv
`timescale 1ns/100ps
`include "adder_tree_cfg.svh"

module adder_tree_top
    import adder_tree_pkg::*;
(
    input  logic         clk,
    input  logic         i_rst_n,
    input  operand_set_t i_data,
    output wide_t        o_sum
);

    localparam int HALF_N = `ADDER_TREE_OPS_N / 2;

    csa_pair_t pair_lo;
    csa_pair_t pair_hi;

    //////////////////////////////////////////////////
    // two half trees
    //////////////////////////////////////////////////

    // lanes 0..7
    csa_reduction_tree #(
        .P_OPS_N (HALF_N)
    ) u_tree_lo (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_ops   (i_data[HALF_N-1:0]),
        .o_pair  (pair_lo)
    );

    // lanes 8..15
    csa_reduction_tree #(
        .P_OPS_N (HALF_N)
    ) u_tree_hi (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_ops   (i_data[`ADDER_TREE_OPS_N-1:HALF_N]),
        .o_pair  (pair_hi)
    );

    // merge and final add
    tree_merge u_merge (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_lo    (pair_lo),
        .i_hi    (pair_hi),
        .o_sum   (o_sum)
    );

endmodule

//--- test/adder_tree_tb.sv
`timescale 1ns/100ps
`include "adder_tree_cfg.svh"

module adder_tree_tb
    import adder_tree_pkg::*;
();

    //////////////////////////////////////////////////
    // run sizing
    //////////////////////////////////////////////////

    localparam int CLK_PERIOD = 100;
    localparam int RST_CYCLES = 16;
    localparam int LAT = `ADDER_TREE_LATENCY;

    // all 7, all 0, one per lane, two half imbalance entries
    localparam int DIRECTED_N = 2 + `ADDER_TREE_OPS_N + 2;
    localparam int RAND_N = 48;
    // reset pulse lands right after the last of these, several still in flight
    localparam int PRE_N = 10;
    localparam int POST_N = 12;
    localparam int TBL_N = DIRECTED_N + RAND_N + PRE_N + POST_N;

    localparam int PRE_FIRST = DIRECTED_N + RAND_N;
    localparam int POST_FIRST = PRE_FIRST + PRE_N;

    localparam int WATCHDOG_NS = (RST_CYCLES + TBL_N + 2 * LAT) * CLK_PERIOD * 2;

    logic         clk;
    logic         i_rst_n;
    operand_set_t i_data;
    wide_t        o_sum;

    operand_set_t tbl_data [TBL_N];
    wide_t        tbl_exp [TBL_N];
    int           fill_idx;

    logic [31:0] lfsr_state;
    int          errors;
    int          checks;

    adder_tree_top dut_i (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .i_data  (i_data),
        .o_sum   (o_sum)
    );

    initial begin
        clk = 1'b0;
    end

    always #(CLK_PERIOD / 2) clk = ~clk;

    //////////////////////////////////////////////////
    // random source
    //////////////////////////////////////////////////

    // x^32 + x^22 + x^2 + x + 1, one step per bit
    function automatic logic next_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic operand_set_t random_set();
        operand_set_t d;
        for (int i = 0; i < `ADDER_TREE_OPS_N; i++) begin
            for (int b = 0; b < `ADDER_TREE_OP_W; b++) begin
                d[i][b] = next_bit();
            end
        end
        return d;
    endfunction

    //////////////////////////////////////////////////
    // stimulus table
    //////////////////////////////////////////////////

    // plain integer total of all lanes
    function automatic int lane_total(input operand_set_t d);
        int total;
        total = 0;
        for (int i = 0; i < `ADDER_TREE_OPS_N; i++) begin
            total += int'(d[i]);
        end
        return total;
    endfunction

    task automatic add_entry(input operand_set_t d);
        tbl_data[fill_idx] = d;
        tbl_exp[fill_idx] = wide_t'(lane_total(d));
        fill_idx++;
    endtask

    task automatic fill_table();
        operand_set_t d;
        fill_idx = 0;

        // full scale, then empty
        for (int i = 0; i < `ADDER_TREE_OPS_N; i++) begin
            d[i] = 3'd7;
        end
        add_entry(d);
        add_entry('0);

        // walking lane, value 5
        for (int lane = 0; lane < `ADDER_TREE_OPS_N; lane++) begin
            d = '0;
            d[lane] = 3'd5;
            add_entry(d);
        end

        // low half at max, then high half at max
        for (int i = 0; i < `ADDER_TREE_OPS_N; i++) begin
            d[i] = (i < `ADDER_TREE_OPS_N / 2) ? 3'd7 : 3'd0;
        end
        add_entry(d);
        for (int i = 0; i < `ADDER_TREE_OPS_N; i++) begin
            d[i] = (i < `ADDER_TREE_OPS_N / 2) ? 3'd0 : 3'd7;
        end
        add_entry(d);

        // random streaming plus the two reset phases
        for (int k = DIRECTED_N; k < TBL_N; k++) begin
            add_entry(random_set());
        end
    endtask

    //////////////////////////////////////////////////
    // checking
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s at %0t ns: got 0x%0h, expected 0x%0h", name, $time, got, exp);
        end
    endtask

    // one entry per cycle, result for entry k checked LAT cycles later
    task automatic stream_entries(input int first, input int count);
        for (int c = 0; c < count + LAT; c++) begin
            @(posedge clk);
            #1;
            if (c >= LAT) begin
                check_value($sformatf("o_sum entry %0d", first + c - LAT),
                            32'(o_sum), 32'(tbl_exp[first + c - LAT]));
            end else begin
                // pipeline still holds only zero sets here
                check_value("o_sum before first result", 32'(o_sum), 32'd0);
            end
            if (c < count) begin
                i_data = tbl_data[first + c];
            end else begin
                i_data = '0;
            end
        end
    endtask

    // stream cut short by an asynchronous reset pulse
    task automatic stream_with_reset(input int first, input int count);
        for (int c = 0; c < count; c++) begin
            @(posedge clk);
            #1;
            if (c >= LAT) begin
                check_value($sformatf("o_sum entry %0d", first + c - LAT),
                            32'(o_sum), 32'(tbl_exp[first + c - LAT]));
            end
            i_data = tbl_data[first + c];
        end

        // assert between edges, output must clear without a clock
        @(posedge clk);
        #1;
        i_rst_n = 1'b0;
        #1;
        check_value("o_sum right after reset", 32'(o_sum), 32'd0);
        i_data = '0;

        repeat (3) begin
            @(posedge clk);
            #1;
            check_value("o_sum held in reset", 32'(o_sum), 32'd0);
        end
        i_rst_n = 1'b1;
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        i_rst_n = 1'b0;
        i_data = '0;
        errors = 0;
        checks = 0;
        lfsr_state = 32'haf2f8aa1;

        fill_table();

        repeat (RST_CYCLES) begin
            @(posedge clk);
            #1;
            check_value("o_sum during reset", 32'(o_sum), 32'd0);
        end
        i_rst_n = 1'b1;

        // directed entries and random burst back to back
        stream_entries(0, DIRECTED_N + RAND_N);

        stream_with_reset(PRE_FIRST, PRE_N);
        stream_entries(POST_FIRST, POST_N);

        $display("errors: %0d, checks: %0d", errors, checks);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WATCHDOG_NS);
        errors++;
        $display("simulation timed out after %0d ns without finishing", WATCHDOG_NS);
        $display("errors: %0d, checks: %0d", errors, checks);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- compile.f
+incdir+logic
logic/adder_tree_pkg.sv
logic/csa_reduction_tree.sv
logic/tree_merge.sv
logic/adder_tree_top.sv
test/adder_tree_tb.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = adder_tree_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST OK" $(LOG) || (echo "simulation did not pass" && exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
